/* design/frontend_pkg.sv */
`default_nettype none

package frontend_pkg;

  // width of a register, an address and an instruction word in RV32I
  localparam int unsigned xlen = 32;

  // program-order number attached to every fetched instruction
  // 64 bits is wide enough that it never wraps in practice
  localparam int unsigned order_width = 64;

  // coarse opcode class produced by the decoder
  // the back end uses it to pick a functional unit and an immediate format
  typedef enum logic [3:0] {
    // U-type, load upper immediate
    op_lui     = 4'd0,
    // U-type, add upper immediate to pc
    op_auipc   = 4'd1,
    // J-type, jump and link
    op_jal     = 4'd2,
    // I-type, jump and link through a register
    op_jalr    = 4'd3,
    // B-type, conditional branches
    op_branch  = 4'd4,
    // I-type loads
    op_load    = 4'd5,
    // S-type stores
    op_store   = 4'd6,
    // I-type register-immediate arithmetic
    op_imm     = 4'd7,
    // R-type register-register arithmetic
    op_reg     = 4'd8,
    // anything the front end does not recognise
    op_illegal = 4'd9
  } opclass_e;

  // phase of a four-phase req/ack handshake seen from the requester side
  // the same encoding serves the memory link and the issue link
  typedef enum logic [1:0] {
    // req low and ack low, free to start a new transfer
    hs_idle         = 2'd0,
    // req high, waiting for the responder to raise ack
    hs_wait_ack     = 2'd1,
    // req dropped again, waiting for ack to return low
    hs_wait_release = 2'd2
  } hs_state_e;

endpackage

`default_nettype wire

/* design/fetch_ctrl.sv */
`default_nettype none

module fetch_ctrl #(
  // address of the very first fetch after reset, must be word aligned
  parameter logic [frontend_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                                 clk,
  input  logic                                 rst,

  // instruction memory link, this block is the requester
  output logic                                 imem_req,
  output logic [frontend_pkg::xlen-1:0]        imem_addr,
  input  logic                                 imem_ack,
  input  logic [frontend_pkg::xlen-1:0]        imem_rdata,

  // issue link toward the back end, this block is the requester
  output logic                                 issue_req,
  input  logic                                 issue_ack,

  // write side of the instruction queue
  output logic                                 push,
  output logic [frontend_pkg::xlen-1:0]        push_word,
  output logic [frontend_pkg::xlen-1:0]        push_pc,
  output logic [frontend_pkg::order_width-1:0] push_order,

  // read side of the instruction queue
  output logic                                 pop,
  input  logic                                 full,
  input  logic                                 head_valid
);

  // handshake phase of each link
  frontend_pkg::hs_state_e fetch_state;
  frontend_pkg::hs_state_e issue_state;

  // address of the next word to fetch and its program-order number
  logic [frontend_pkg::xlen-1:0]        fetch_pc;
  logic [frontend_pkg::order_width-1:0] fetch_order;

  // req is high exactly while the machine waits for ack
  // since the state is a register, req changes only on clock edges
  assign imem_req  = (fetch_state == frontend_pkg::hs_wait_ack);
  assign issue_req = (issue_state == frontend_pkg::hs_wait_ack);

  // the address is held in fetch_pc and only moves after the ack,
  // so it stays stable for the whole time req is high
  assign imem_addr = fetch_pc;

  // the returned word goes into the queue on the edge that sees the ack
  assign push       = (fetch_state == frontend_pkg::hs_wait_ack) && imem_ack;
  assign push_word  = imem_rdata;
  assign push_pc    = fetch_pc;
  assign push_order = fetch_order;

  // the head leaves the queue on the edge that first sees issue_ack
  assign pop = (issue_state == frontend_pkg::hs_wait_ack) && issue_ack;

  // fetch side sequencing
  // only one fetch is ever outstanding, so a not-full check in idle
  // still holds when the data arrives
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_state <= frontend_pkg::hs_idle;
      fetch_pc    <= reset_pc;
      fetch_order <= '0;
    end else begin
      case (fetch_state)
        frontend_pkg::hs_idle: begin
          // a full queue keeps the request low until a slot frees up
          if (!full) begin
            fetch_state <= frontend_pkg::hs_wait_ack;
          end
        end
        frontend_pkg::hs_wait_ack: begin
          if (imem_ack) begin
            // the word is pushed on this edge, step to the next one
            fetch_state <= frontend_pkg::hs_wait_release;
            fetch_pc    <= fetch_pc + frontend_pkg::xlen'(4);
            fetch_order <= fetch_order + 1'b1;
          end
        end
        frontend_pkg::hs_wait_release: begin
          // a new request may only start once the memory drops ack
          if (!imem_ack) begin
            fetch_state <= frontend_pkg::hs_idle;
          end
        end
        default: begin
          fetch_state <= frontend_pkg::hs_idle;
        end
      endcase
    end
  end

  // issue side sequencing
  // a word pushed on one edge is seen valid in idle on the next edge,
  // so it always sits in the queue for at least one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      issue_state <= frontend_pkg::hs_idle;
    end else begin
      case (issue_state)
        frontend_pkg::hs_idle: begin
          if (head_valid) begin
            issue_state <= frontend_pkg::hs_wait_ack;
          end
        end
        frontend_pkg::hs_wait_ack: begin
          // pop happens on this same edge through the pop output
          if (issue_ack) begin
            issue_state <= frontend_pkg::hs_wait_release;
          end
        end
        frontend_pkg::hs_wait_release: begin
          if (!issue_ack) begin
            issue_state <= frontend_pkg::hs_idle;
          end
        end
        default: begin
          issue_state <= frontend_pkg::hs_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/instruction_queue.sv */
`default_nettype none

module instruction_queue #(
  // log2 of the number of slots, one or more
  parameter int unsigned queue_depth_log2 = 2
) (
  input  logic                                 clk,
  input  logic                                 rst,

  // write side, only asserted while full is low
  input  logic                                 push,
  input  logic [frontend_pkg::xlen-1:0]        push_word,
  input  logic [frontend_pkg::xlen-1:0]        push_pc,
  input  logic [frontend_pkg::order_width-1:0] push_order,

  // read side, only asserted while head_valid is high
  input  logic                                 pop,

  output logic                                 full,
  output logic                                 head_valid,
  output logic [frontend_pkg::xlen-1:0]        head_word,
  output logic [frontend_pkg::xlen-1:0]        head_pc,
  output logic [frontend_pkg::order_width-1:0] head_order
);

  localparam int unsigned depth = 2 ** queue_depth_log2;

  // ring pointers wrap naturally because depth is a power of two
  logic [queue_depth_log2-1:0] wr_ptr;
  logic [queue_depth_log2-1:0] rd_ptr;

  // one occupancy bit per slot
  logic [depth-1:0] slot_valid;

  // payload storage
  logic [frontend_pkg::xlen-1:0]        word_mem  [depth];
  logic [frontend_pkg::xlen-1:0]        pc_mem    [depth];
  logic [frontend_pkg::order_width-1:0] order_mem [depth];

  // the slot we would write next is still occupied when the ring is full
  assign full       = slot_valid[wr_ptr];
  assign head_valid = slot_valid[rd_ptr];

  // head is read combinationally so decode sees it in the same cycle
  assign head_word  = word_mem[rd_ptr];
  assign head_pc    = pc_mem[rd_ptr];
  assign head_order = order_mem[rd_ptr];

  // pointers and occupancy
  // push and pop never touch the same slot in one cycle since push needs
  // a free slot at wr_ptr and pop needs an occupied one at rd_ptr
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      slot_valid <= '0;
    end else begin
      if (pop) begin
        slot_valid[rd_ptr] <= 1'b0;
        rd_ptr             <= rd_ptr + 1'b1;
      end
      if (push) begin
        slot_valid[wr_ptr] <= 1'b1;
        wr_ptr             <= wr_ptr + 1'b1;
      end
    end
  end

  // payload written on the push edge
  always_ff @(posedge clk) begin
    if (push) begin
      word_mem[wr_ptr]  <= push_word;
      pc_mem[wr_ptr]    <= push_pc;
      order_mem[wr_ptr] <= push_order;
    end
  end

endmodule

`default_nettype wire

/* design/instr_decode.sv */
`default_nettype none

module instr_decode (
  input  logic [frontend_pkg::xlen-1:0] word,
  output frontend_pkg::opclass_e        opclass,
  output logic [2:0]                    funct3,
  output logic [6:0]                    funct7,
  output logic [4:0]                    rs1,
  output logic [4:0]                    rs2,
  output logic [4:0]                    rd,
  output logic [frontend_pkg::xlen-1:0] imm
);

  // major opcodes of the RV32I base set, bits [6:0]
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_imm    = 7'b0010011;
  localparam logic [6:0] opc_reg    = 7'b0110011;

  // candidate immediates, one per instruction format
  logic [frontend_pkg::xlen-1:0] imm_i;
  logic [frontend_pkg::xlen-1:0] imm_s;
  logic [frontend_pkg::xlen-1:0] imm_b;
  logic [frontend_pkg::xlen-1:0] imm_u;
  logic [frontend_pkg::xlen-1:0] imm_j;

  // register and function fields sit at fixed positions in every format,
  // so they are passed out raw and the back end ignores what it does not need
  assign funct3 = word[14:12];
  assign funct7 = word[31:25];
  assign rs1    = word[19:15];
  assign rs2    = word[24:20];
  assign rd     = word[11:7];

  // bit 31 is the sign bit in all formats
  assign imm_i = {{20{word[31]}}, word[31:20]};
  assign imm_s = {{20{word[31]}}, word[31:25], word[11:7]};
  // branch and jump offsets are multiples of two, bit 0 is implied
  assign imm_b = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
  assign imm_u = {word[31:12], 12'b0};
  assign imm_j = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};

  // classify the major opcode
  always_comb begin
    case (word[6:0])
      opc_lui:    opclass = frontend_pkg::op_lui;
      opc_auipc:  opclass = frontend_pkg::op_auipc;
      opc_jal:    opclass = frontend_pkg::op_jal;
      opc_jalr:   opclass = frontend_pkg::op_jalr;
      opc_branch: opclass = frontend_pkg::op_branch;
      opc_load:   opclass = frontend_pkg::op_load;
      opc_store:  opclass = frontend_pkg::op_store;
      opc_imm:    opclass = frontend_pkg::op_imm;
      opc_reg:    opclass = frontend_pkg::op_reg;
      default:    opclass = frontend_pkg::op_illegal;
    endcase
  end

  // pick the immediate that belongs to the class
  // register ops and illegal words carry no immediate at all
  always_comb begin
    case (opclass)
      frontend_pkg::op_jalr,
      frontend_pkg::op_load,
      frontend_pkg::op_imm:    imm = imm_i;
      frontend_pkg::op_store:  imm = imm_s;
      frontend_pkg::op_branch: imm = imm_b;
      frontend_pkg::op_lui,
      frontend_pkg::op_auipc:  imm = imm_u;
      frontend_pkg::op_jal:    imm = imm_j;
      default:                 imm = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/frontend_top.sv */
`default_nettype none

module frontend_top #(
  parameter int unsigned                   queue_depth_log2 = 2,
  parameter logic [frontend_pkg::xlen-1:0] reset_pc         = '0
) (
  input  logic                                 clk,
  input  logic                                 rst,

  // instruction memory link
  output logic                                 imem_req,
  output logic [frontend_pkg::xlen-1:0]        imem_addr,
  input  logic                                 imem_ack,
  input  logic [frontend_pkg::xlen-1:0]        imem_rdata,

  // issue link to the back end
  output logic                                 issue_req,
  input  logic                                 issue_ack,
  output logic [frontend_pkg::xlen-1:0]        issue_pc,
  output logic [frontend_pkg::order_width-1:0] issue_order,
  output frontend_pkg::opclass_e               issue_opclass,
  output logic [2:0]                           issue_funct3,
  output logic [6:0]                           issue_funct7,
  output logic [4:0]                           issue_rs1,
  output logic [4:0]                           issue_rs2,
  output logic [4:0]                           issue_rd,
  output logic [frontend_pkg::xlen-1:0]        issue_imm
);

  // queue write side
  logic                                 push;
  logic [frontend_pkg::xlen-1:0]        push_word;
  logic [frontend_pkg::xlen-1:0]        push_pc;
  logic [frontend_pkg::order_width-1:0] push_order;

  // queue read side and status
  logic                                 pop;
  logic                                 full;
  logic                                 head_valid;
  logic [frontend_pkg::xlen-1:0]        head_word;

  // sequencing of both handshakes, pc and order counters
  fetch_ctrl #(
    .reset_pc (reset_pc)
  ) u_fetch_ctrl (
    .clk        (clk),
    .rst        (rst),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .imem_ack   (imem_ack),
    .imem_rdata (imem_rdata),
    .issue_req  (issue_req),
    .issue_ack  (issue_ack),
    .push       (push),
    .push_word  (push_word),
    .push_pc    (push_pc),
    .push_order (push_order),
    .pop        (pop),
    .full       (full),
    .head_valid (head_valid)
  );

  // pc and order of the head go straight out with the decoded fields
  instruction_queue #(
    .queue_depth_log2 (queue_depth_log2)
  ) u_instruction_queue (
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .push_word  (push_word),
    .push_pc    (push_pc),
    .push_order (push_order),
    .pop        (pop),
    .full       (full),
    .head_valid (head_valid),
    .head_word  (head_word),
    .head_pc    (issue_pc),
    .head_order (issue_order)
  );

  // zero-latency decode of the word at the queue head
  instr_decode u_instr_decode (
    .word    (head_word),
    .opclass (issue_opclass),
    .funct3  (issue_funct3),
    .funct7  (issue_funct7),
    .rs1     (issue_rs1),
    .rs2     (issue_rs2),
    .rd      (issue_rd),
    .imm     (issue_imm)
  );

endmodule

`default_nettype wire

/* verif/imem_model.sv */
`default_nettype none

module imem_model (
  input  logic                          clk,
  // four-phase link where this model is the responder
  input  logic                          req,
  input  logic [frontend_pkg::xlen-1:0] addr,
  output logic                          ack,
  output logic [frontend_pkg::xlen-1:0] rdata
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned entries = 64;

  // one opcode per class, the last one is reserved in RV32I and must decode as illegal
  localparam logic [6:0] templates [10] = '{
    7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011,
    7'b0000011, 7'b0100011, 7'b0010011, 7'b0110011, 7'b1111111
  };

  // the testbench reads this array too when it works out expected fields
  logic [frontend_pkg::xlen-1:0] encodings [entries];

  // random upper fields on top of a rotating opcode so every class shows up
  task automatic build_table();
    logic [frontend_pkg::xlen-1:0] word;
    for (int i = 0; i < entries; i++) begin
      word         = $urandom();
      word[6:0]    = templates[i % 10];
      encodings[i] = word;
    end
  endtask

  // responder side of the handshake
  // req is read just after the edge, so it still holds the value the DUT drove before it
  initial begin
    ack   = 1'b0;
    rdata = '0;
    forever begin
      @(posedge clk);
      if (req === 1'b1 && !ack) begin
        repeat ($urandom_range(3, 0)) @(posedge clk);
        ack   <= 1'b1;
        rdata <= encodings[addr[7:2]];
      end else if (req === 1'b0 && ack) begin
        ack <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* verif/frontend_tb.sv */
`default_nettype none

module frontend_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned queue_depth_log2 = 2;
  localparam logic [31:0] reset_pc         = 32'h0;
  localparam int          queue_slots      = 2 ** queue_depth_log2;
  localparam int          total_issues     = 128;

  logic                                 clk;
  logic                                 rst;
  logic                                 imem_req;
  logic [31:0]                          imem_addr;
  logic                                 imem_ack;
  logic [31:0]                          imem_rdata;
  logic                                 issue_req;
  logic                                 issue_ack;
  logic [31:0]                          issue_pc;
  logic [63:0]                          issue_order;
  frontend_pkg::opclass_e               issue_opclass;
  logic [2:0]                           issue_funct3;
  logic [6:0]                           issue_funct7;
  logic [4:0]                           issue_rs1;
  logic [4:0]                           issue_rs2;
  logic [4:0]                           issue_rd;
  logic [31:0]                          issue_imm;

  // words taken from memory and words handed to the back end so far
  int fetch_count = 0;
  int issue_count = 0;

  // copies of the previous sample for the protocol checks
  logic         rst_q       = 1'b0;
  logic         imem_req_q  = 1'b0;
  logic         imem_ack_q  = 1'b0;
  logic         issue_req_q = 1'b0;
  logic         issue_ack_q = 1'b0;
  logic [31:0]  imem_addr_q;
  // every issue output packed together so one compare covers them all
  logic [156:0] issue_bundle;
  logic [156:0] issue_bundle_q;

  // what the head of the issue link should look like right now
  logic [31:0]            expected_pc;
  logic [31:0]            expected_word;
  frontend_pkg::opclass_e expected_opclass;
  logic [31:0]            expected_imm;
  // class and raw register and function fields in the same order as the bundle
  logic [28:0]            expected_fields;

  frontend_top #(
    .queue_depth_log2 (queue_depth_log2),
    .reset_pc         (reset_pc)
  ) dut0 (
    .clk (clk), .rst (rst),
    .imem_req (imem_req), .imem_addr (imem_addr), .imem_ack (imem_ack), .imem_rdata (imem_rdata),
    .issue_req (issue_req), .issue_ack (issue_ack), .issue_pc (issue_pc),
    .issue_order (issue_order), .issue_opclass (issue_opclass), .issue_funct3 (issue_funct3),
    .issue_funct7 (issue_funct7), .issue_rs1 (issue_rs1), .issue_rs2 (issue_rs2),
    .issue_rd (issue_rd), .issue_imm (issue_imm)
  );

  imem_model mem0 (
    .clk (clk), .req (imem_req), .addr (imem_addr),
    .ack (imem_ack), .rdata (imem_rdata)
  );

  // major opcode map of the base integer set
  function automatic frontend_pkg::opclass_e classify(input logic [31:0] word);
    case (word[6:0])
      7'h37:   return frontend_pkg::op_lui;
      7'h17:   return frontend_pkg::op_auipc;
      7'h6f:   return frontend_pkg::op_jal;
      7'h67:   return frontend_pkg::op_jalr;
      7'h63:   return frontend_pkg::op_branch;
      7'h03:   return frontend_pkg::op_load;
      7'h23:   return frontend_pkg::op_store;
      7'h13:   return frontend_pkg::op_imm;
      7'h33:   return frontend_pkg::op_reg;
      default: return frontend_pkg::op_illegal;
    endcase
  endfunction

  // signed assignment from a narrow field does the sign extension
  function automatic logic [31:0] immediate_of(input logic [31:0] word,
                                               input frontend_pkg::opclass_e cls);
    logic signed [31:0] value;
    case (cls)
      frontend_pkg::op_jalr, frontend_pkg::op_load, frontend_pkg::op_imm:
        value = $signed(word[31:20]);
      frontend_pkg::op_store:  value = $signed({word[31:25], word[11:7]});
      frontend_pkg::op_branch: value = $signed({word[31], word[7], word[30:25], word[11:8], 1'b0});
      frontend_pkg::op_lui, frontend_pkg::op_auipc: value = {word[31:12], 12'h000};
      frontend_pkg::op_jal: value = $signed({word[31], word[19:12], word[20], word[30:21], 1'b0});
      default: value = 32'sd0;
    endcase
    return value;
  endfunction

  task automatic fail_check(input string name, input logic [159:0] expected,
                            input logic [159:0] actual);
    $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
    $display("tests failed");
    $fatal(1, "check %s did not hold", name);
  endtask

  // the k-th issued word must be the one stored at reset_pc + 4k
  assign expected_pc      = reset_pc + 32'(issue_count) * 32'd4;
  assign expected_word    = mem0.encodings[expected_pc[7:2]];
  assign expected_opclass = classify(expected_word);
  assign expected_imm     = immediate_of(expected_word, expected_opclass);
  assign expected_fields  = {expected_opclass, expected_word[14:12], expected_word[31:25],
                             expected_word[19:15], expected_word[24:20], expected_word[11:7]};
  assign issue_bundle     = {issue_pc, issue_order, issue_opclass, issue_funct3, issue_funct7,
                             issue_rs1, issue_rs2, issue_rd, issue_imm};

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // a transfer on either link completes on the edge that sees req and ack both high
  always @(posedge clk) begin
    if (rst) begin
      fetch_count <= 0;
      issue_count <= 0;
    end else begin
      if (imem_req && imem_ack) fetch_count <= fetch_count + 1;
      if (issue_req && issue_ack) issue_count <= issue_count + 1;
    end
    rst_q          <= rst;
    imem_req_q     <= imem_req;
    imem_ack_q     <= imem_ack;
    imem_addr_q    <= imem_addr;
    issue_req_q    <= issue_req;
    issue_ack_q    <= issue_ack;
    issue_bundle_q <= issue_bundle;
  end

  // back end that answers each offer after a random wait so the queue fills now and then
  initial begin
    issue_ack = 1'b0;
    forever begin
      @(posedge clk);
      if (issue_req === 1'b1 && !issue_ack) begin
        repeat ($urandom_range(6, 0)) @(posedge clk);
        issue_ack <= 1'b1;
      end else if (issue_req === 1'b0 && issue_ack) begin
        issue_ack <= 1'b0;
      end
    end
  end

  // every offered instruction is compared against the table and the reference decoder
  order_pc_check: assert property (@(posedge clk) disable iff (rst)
    issue_req |-> {issue_order, issue_pc} == {64'(issue_count), expected_pc})
    else fail_check("order_pc", {64'($sampled(issue_count)), $sampled(expected_pc)},
                    {$sampled(issue_order), $sampled(issue_pc)});
  fields_check: assert property (@(posedge clk) disable iff (rst) issue_req |->
    {issue_opclass, issue_funct3, issue_funct7, issue_rs1, issue_rs2, issue_rd} ==
    expected_fields)
    else fail_check("decode_fields", $sampled(expected_fields),
                    $sampled(issue_bundle[60:32]));
  imm_check: assert property (@(posedge clk) disable iff (rst)
    issue_req |-> issue_imm == expected_imm)
    else fail_check("immediate", $sampled(expected_imm), $sampled(issue_imm));

  // req may only drop after its ack, and only rises again once ack is low
  imem_hold_check: assert property (@(posedge clk) disable iff (rst)
    imem_req_q && !imem_ack_q |-> imem_req) else fail_check("imem_req_hold", 1, 0);
  issue_hold_check: assert property (@(posedge clk) disable iff (rst)
    issue_req_q && !issue_ack_q |-> issue_req) else fail_check("issue_req_hold", 1, 0);
  imem_rise_check: assert property (@(posedge clk) disable iff (rst)
    imem_req && !imem_req_q |-> !imem_ack_q) else fail_check("imem_req_rise", 0, 1);
  issue_rise_check: assert property (@(posedge clk) disable iff (rst)
    issue_req && !issue_req_q |-> !issue_ack_q) else fail_check("issue_req_rise", 0, 1);
  // whatever the requester offers must not move until the transfer is over
  imem_stable_check: assert property (@(posedge clk) disable iff (rst)
    imem_req && imem_req_q |-> imem_addr == imem_addr_q)
    else fail_check("imem_addr_stable", $sampled(imem_addr_q), $sampled(imem_addr));
  issue_stable_check: assert property (@(posedge clk) disable iff (rst)
    issue_req && issue_req_q |-> issue_bundle == issue_bundle_q)
    else fail_check("issue_stable", $sampled(issue_bundle_q), $sampled(issue_bundle));

  // the queue bounds the distance between fetch and issue
  occupancy_check: assert property (@(posedge clk) disable iff (rst)
    fetch_count - issue_count <= queue_slots)
    else fail_check("occupancy", queue_slots, $sampled(fetch_count - issue_count));
  stall_check: assert property (@(posedge clk) disable iff (rst)
    imem_req && !imem_req_q |-> fetch_count - issue_count < queue_slots)
    else fail_check("fetch_stall", queue_slots - 1, $sampled(fetch_count - issue_count));
  first_addr_check: assert property (@(posedge clk) disable iff (rst)
    imem_req && fetch_count == 0 |-> imem_addr == reset_pc)
    else fail_check("first_fetch_addr", reset_pc, $sampled(imem_addr));
  // rst_q covers the reset cycles and the first cycle after rst drops
  reset_check: assert property (@(posedge clk)
    rst_q |-> !imem_req && !issue_req)
    else fail_check("reset_req_low", 0, {$sampled(imem_req), $sampled(issue_req)});

  initial begin
    rst = 1'b1;
    void'($urandom(65632));
    mem0.build_table();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    while (issue_count < total_issues) @(posedge clk);
    @(posedge clk);
    $display("all tests passed");
    $finish;
  end

  // generous bound of twenty cycles per issued instruction
  initial begin
    repeat (total_issues * 20) @(posedge clk);
    $display("tests failed");
    $fatal(1, "watchdog expired before %0d instructions were issued", total_issues);
  end

endmodule

`default_nettype wire

/* flist.f */
design/frontend_pkg.sv
design/fetch_ctrl.sv
design/instruction_queue.sv
design/instr_decode.sv
design/frontend_top.sv
verif/imem_model.sv
verif/frontend_tb.sv

/* Bender.yml */
package:
  name: rv32i_frontend

sources:
  - design/frontend_pkg.sv
  - design/fetch_ctrl.sv
  - design/instruction_queue.sv
  - design/instr_decode.sv
  - design/frontend_top.sv
  - target: test
    files:
      - verif/imem_model.sv
      - verif/frontend_tb.sv
